// File: common/bru_pkg.sv
// branch resolution unit package: widths, task and bus structs, output structs, op encoding
package bru_pkg;

    ////////////////////
    // widths

    // word-index pc, so pc + 4 bytes is pc + 1
    localparam int PC_WIDTH = 14;
    localparam int WORD_WIDTH = 32;

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [PC_WIDTH-1:0] pc_t;
    typedef logic [5:0] phys_reg_tag_t;
    typedef logic [3:0] rob_index_t;
    typedef logic [2:0] checkpoint_column_t;

    // btb and direction predictor index, low pc bits
    typedef logic [3:0] bp_index_t;

    // operand source code
    // 0..2 pick a complete bus, 3 keeps the raw register word
    typedef logic [1:0] bus_sel_t;
    localparam bus_sel_t BUS_SEL_RAW = 2'd3;

    // branch ops handled here
    typedef enum logic [1:0] {
        BRU_BEQ = 2'd0,
        BRU_BNE = 2'd1,
        BRU_JR  = 2'd2
    } bru_op_t;

    ////////////////////
    // dispatch side

    typedef struct packed {
        logic needed;
        logic ready;
        phys_reg_tag_t phys_reg_tag;
    } source_status_t;

    typedef struct packed {
        bru_op_t op;
        source_status_t source_0;
        source_status_t source_1;
        logic [15:0] imm16;
        pc_t pc;
        // predicted next pc, checked in execute
        pc_t npc;
        checkpoint_column_t checkpoint_column;
        rob_index_t rob_index;
    } bru_task_t;

    // one complete bus; data trails its tag by a cycle
    typedef struct packed {
        logic tag_valid;
        phys_reg_tag_t tag;
        word_t data;
    } cbus_t;

    ////////////////////
    // execute latch

    typedef struct packed {
        bru_op_t op;
        word_t operand_0;
        word_t operand_1;
        bus_sel_t sel_0;
        bus_sel_t sel_1;
        bp_index_t bp_index;
        // pc + 1 + imm
        pc_t target;
        pc_t pc_plus_1;
        pc_t npc;
        checkpoint_column_t checkpoint_column;
        rob_index_t rob_index;
    } ex_task_t;

    ////////////////////
    // outputs

    typedef struct packed {
        rob_index_t rob_index;
        pc_t pc;
        checkpoint_column_t checkpoint_column;
    } restart_t;

    typedef struct packed {
        bp_index_t index;
        pc_t target;
        logic taken;
    } bp_update_t;

endpackage

// File: bru/bru_tag_match.sv
// one source tag against every complete bus, lowest matching bus wins
`timescale 1ns/1ps

module bru_tag_match #(
    parameter int NUM_CBUS = 3
) (
    input bru_pkg::phys_reg_tag_t tag,
    input bru_pkg::cbus_t [NUM_CBUS-1:0] cbus,
    output logic hit,
    output bru_pkg::bus_sel_t sel
);

    import bru_pkg::*;

    ////////////////////
    // priority encode

    always_comb begin
        // no match leaves the raw code
        hit = 1'b0;
        sel = BUS_SEL_RAW;

        // walk down so the lowest bus is written last
        for (int i = NUM_CBUS - 1; i >= 0; i--) begin
            if (cbus[i].tag_valid && (cbus[i].tag == tag)) begin
                hit = 1'b1;
                sel = bus_sel_t'(i);
            end
        end
    end

endmodule

// File: bru/bru_rs_stage.sv
// reservation station stage: holds the dispatched task until operands are in, then issues
`timescale 1ns/1ps

module bru_rs_stage #(
    parameter int NUM_CBUS = 3
) (
    input logic CLK,
    input logic nRST,

    // dispatch
    input logic dispatch_valid,
    input bru_pkg::bru_task_t dispatch_task,

    // complete buses
    input bru_pkg::cbus_t [NUM_CBUS-1:0] cbus,

    // kill from rob
    input logic kill_valid,
    input bru_pkg::rob_index_t kill_rob_index,

    // restart from execute
    input logic flush,

    // register file read
    output logic read_req_valid,
    output bru_pkg::phys_reg_tag_t read_req_tag_0,
    output bru_pkg::phys_reg_tag_t read_req_tag_1,
    input logic read_serviced,
    input bru_pkg::word_t read_data_0,
    input bru_pkg::word_t read_data_1,

    output logic rs_full,

    // into execute latch
    output logic ex_valid_next,
    output bru_pkg::ex_task_t ex_task_next
);

    import bru_pkg::*;

    // rs latch
    logic rs_valid;
    logic rs_valid_next;
    bru_task_t rs_task;
    bru_task_t rs_task_next;

    // bus matches per source
    logic hit_0;
    logic hit_1;
    bus_sel_t match_sel_0;
    bus_sel_t match_sel_1;

    // operand status
    logic read_0;
    logic read_1;
    logic bus_0;
    logic bus_1;
    logic have_0;
    logic have_1;
    logic can_issue;
    logic kill;
    logic issue;

    ////////////////////
    // tag match

    bru_tag_match #(
        .NUM_CBUS(NUM_CBUS)
    ) i_tag_match_0 (
        .tag (rs_task.source_0.phys_reg_tag),
        .cbus(cbus),
        .hit (hit_0),
        .sel (match_sel_0)
    );

    bru_tag_match #(
        .NUM_CBUS(NUM_CBUS)
    ) i_tag_match_1 (
        .tag (rs_task.source_1.phys_reg_tag),
        .cbus(cbus),
        .hit (hit_1),
        .sel (match_sel_1)
    );

    ////////////////////
    // issue decision

    // ready sources come from the register file
    assign read_0 = rs_task.source_0.needed & rs_task.source_0.ready;
    assign read_1 = rs_task.source_1.needed & rs_task.source_1.ready;

    // not yet ready but on a bus this cycle
    assign bus_0 = rs_task.source_0.needed & ~rs_task.source_0.ready & hit_0;
    assign bus_1 = rs_task.source_1.needed & ~rs_task.source_1.ready & hit_1;

    // unneeded source counts as present
    assign have_0 = ~rs_task.source_0.needed | read_0 | bus_0;
    assign have_1 = ~rs_task.source_1.needed | read_1 | bus_1;

    assign kill = rs_valid & kill_valid & (rs_task.rob_index == kill_rob_index);

    // all bus-sourced tasks skip the read
    assign can_issue = have_0 & have_1 & (~(read_0 | read_1) | read_serviced);
    assign issue = rs_valid & ~kill & can_issue;

    // read only asked once every operand is accounted for
    assign read_req_valid = rs_valid & ~kill & have_0 & have_1 & (read_0 | read_1);
    assign read_req_tag_0 = rs_task.source_0.phys_reg_tag;
    assign read_req_tag_1 = rs_task.source_1.phys_reg_tag;

    assign rs_full = rs_valid & ~kill & ~can_issue;

    ////////////////////
    // rs latch

    always_comb begin
        rs_valid_next = rs_valid;
        rs_task_next = rs_task;

        if (kill || issue) begin
            rs_valid_next = 1'b0;
        end else if (rs_valid) begin
            // stalled, remember what went by on the buses
            if (bus_0) begin
                rs_task_next.source_0.ready = 1'b1;
            end
            if (bus_1) begin
                rs_task_next.source_1.ready = 1'b1;
            end
        end

        // new task, may arrive alongside an issue
        if (dispatch_valid) begin
            rs_valid_next = 1'b1;
            rs_task_next = dispatch_task;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            rs_valid <= 1'b0;
            rs_task <= '0;
        end else if (flush) begin
            // restart drops this cycle's dispatch too
            rs_valid <= 1'b0;
            rs_task <= '0;
        end else begin
            rs_valid <= rs_valid_next;
            rs_task <= rs_task_next;
        end
    end

    ////////////////////
    // execute payload

    assign ex_valid_next = issue;

    always_comb begin
        ex_task_next.op = rs_task.op;
        ex_task_next.operand_0 = read_data_0;
        ex_task_next.operand_1 = read_data_1;
        // bus code only for sources caught on a bus
        ex_task_next.sel_0 = bus_0 ? match_sel_0 : BUS_SEL_RAW;
        ex_task_next.sel_1 = bus_1 ? match_sel_1 : BUS_SEL_RAW;
        ex_task_next.bp_index = bp_index_t'(rs_task.pc);
        ex_task_next.pc_plus_1 = rs_task.pc + pc_t'(1);
        // imm truncated to pc width wraps the same as sign extension
        ex_task_next.target = rs_task.pc + pc_t'(1) + pc_t'(rs_task.imm16[PC_WIDTH-1:0]);
        ex_task_next.npc = rs_task.npc;
        ex_task_next.checkpoint_column = rs_task.checkpoint_column;
        ex_task_next.rob_index = rs_task.rob_index;
    end

endmodule

// File: bru/bru_ex_stage.sv
// execute stage: resolves the branch, raises complete, restart and predictor update
`timescale 1ns/1ps

module bru_ex_stage #(
    parameter int NUM_CBUS = 3
) (
    input logic CLK,
    input logic nRST,

    // from rs stage
    input logic ex_valid_next,
    input bru_pkg::ex_task_t ex_task_next,

    // complete buses, data for forwarded operands
    input bru_pkg::cbus_t [NUM_CBUS-1:0] cbus,

    // to rob
    output logic complete_valid,
    output logic restart_valid,
    output bru_pkg::restart_t restart,

    // to fetch predictors
    output logic bp_update_valid,
    output bru_pkg::bp_update_t bp_update,

    // clears both latches
    output logic flush
);

    import bru_pkg::*;

    // ex latch
    logic ex_valid;
    ex_task_t ex_task;

    // resolved operands
    word_t operand_a;
    word_t operand_b;

    logic branch_taken;
    logic cond_branch;
    pc_t expected_pc;

    // bus data if named, else the raw register word
    function automatic word_t pick_operand(
        input bus_sel_t sel,
        input word_t raw,
        input cbus_t [NUM_CBUS-1:0] buses
    );
        word_t value;
        value = raw;
        for (int i = 0; i < NUM_CBUS; i++) begin
            if (sel == bus_sel_t'(i)) begin
                value = buses[i].data;
            end
        end
        return value;
    endfunction

    ////////////////////
    // ex latch

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ex_valid <= 1'b0;
            ex_task <= '0;
        end else if (flush) begin
            ex_valid <= 1'b0;
            ex_task <= '0;
        end else begin
            ex_valid <= ex_valid_next;
            ex_task <= ex_task_next;
        end
    end

    ////////////////////
    // operand mux

    // bus data lands this cycle, one after the tag match
    assign operand_a = pick_operand(ex_task.sel_0, ex_task.operand_0, cbus);
    assign operand_b = pick_operand(ex_task.sel_1, ex_task.operand_1, cbus);

    ////////////////////
    // resolution

    assign cond_branch = (ex_task.op == BRU_BEQ) || (ex_task.op == BRU_BNE);

    always_comb begin
        branch_taken = 1'b0;
        expected_pc = ex_task.pc_plus_1;

        case (ex_task.op)
            BRU_BEQ: begin
                branch_taken = (operand_a == operand_b);
            end
            BRU_BNE: begin
                branch_taken = (operand_a != operand_b);
            end
            default: begin
                branch_taken = 1'b0;
            end
        endcase

        // jr target is the byte address in operand 0
        if (ex_task.op == BRU_JR) begin
            expected_pc = operand_a[PC_WIDTH+1:2];
        end else if (branch_taken) begin
            expected_pc = ex_task.target;
        end
    end

    ////////////////////
    // outputs

    assign complete_valid = ex_valid;

    // mispredict when fetch went elsewhere
    assign restart_valid = ex_valid && (ex_task.npc != expected_pc);
    assign flush = restart_valid;

    assign restart.rob_index = ex_task.rob_index;
    assign restart.pc = expected_pc;
    assign restart.checkpoint_column = ex_task.checkpoint_column;

    // jr leaves the predictors alone
    assign bp_update_valid = ex_valid & cond_branch;
    assign bp_update.index = ex_task.bp_index;
    assign bp_update.target = ex_task.target;
    assign bp_update.taken = branch_taken;

endmodule

// File: hdl/bru_pipeline.sv
// branch resolution unit top: rs stage feeding a single-cycle execute stage
`timescale 1ns/1ps

module bru_pipeline #(
    // complete buses watched, at most 3
    parameter int NUM_CBUS = 3
) (
    input logic CLK,
    input logic nRST,

    // dispatch
    input logic dispatch_valid,
    input bru_pkg::bru_task_t dispatch_task,
    output logic rs_full,

    // register file read
    output logic read_req_valid,
    output bru_pkg::phys_reg_tag_t read_req_tag_0,
    output bru_pkg::phys_reg_tag_t read_req_tag_1,
    input logic read_serviced,
    input bru_pkg::word_t read_data_0,
    input bru_pkg::word_t read_data_1,

    // kill from rob
    input logic kill_valid,
    input bru_pkg::rob_index_t kill_rob_index,

    // complete buses
    input bru_pkg::cbus_t [NUM_CBUS-1:0] cbus,

    // resolution
    output logic complete_valid,
    output logic restart_valid,
    output bru_pkg::restart_t restart,
    output logic bp_update_valid,
    output bru_pkg::bp_update_t bp_update
);

    import bru_pkg::*;

    ////////////////////
    // stage links

    logic ex_valid_next;
    ex_task_t ex_task_next;
    // restart back into both latches
    logic flush;

    bru_rs_stage #(
        .NUM_CBUS(NUM_CBUS)
    ) i_rs_stage (
        .CLK           (CLK),
        .nRST          (nRST),
        .dispatch_valid(dispatch_valid),
        .dispatch_task (dispatch_task),
        .cbus          (cbus),
        .kill_valid    (kill_valid),
        .kill_rob_index(kill_rob_index),
        .flush         (flush),
        .read_req_valid(read_req_valid),
        .read_req_tag_0(read_req_tag_0),
        .read_req_tag_1(read_req_tag_1),
        .read_serviced (read_serviced),
        .read_data_0   (read_data_0),
        .read_data_1   (read_data_1),
        .rs_full       (rs_full),
        .ex_valid_next (ex_valid_next),
        .ex_task_next  (ex_task_next)
    );

    bru_ex_stage #(
        .NUM_CBUS(NUM_CBUS)
    ) i_ex_stage (
        .CLK            (CLK),
        .nRST           (nRST),
        .ex_valid_next  (ex_valid_next),
        .ex_task_next   (ex_task_next),
        .cbus           (cbus),
        .complete_valid (complete_valid),
        .restart_valid  (restart_valid),
        .restart        (restart),
        .bp_update_valid(bp_update_valid),
        .bp_update      (bp_update),
        .flush          (flush)
    );

endmodule

// File: testbench/tb_bru_pipeline.sv
// testbench for the branch resolution pipeline: directed and random tasks against reference rules
`timescale 1ns/1ps

module tb_bru_pipeline;

    import bru_pkg::*;

    localparam int NUM_CBUS = 3;
    localparam int WAIT_LIMIT = 20;

    // one expected completion
    typedef struct packed {
        rob_index_t rob_index;
        checkpoint_column_t checkpoint_column;
        logic restart;
        pc_t restart_pc;
        logic bp_valid;
        logic taken;
        pc_t target;
        bp_index_t index;
    } expect_t;

    logic CLK = 1'b0;
    logic nRST;
    logic dispatch_valid;
    bru_task_t dispatch_task;
    logic rs_full;
    logic read_req_valid;
    phys_reg_tag_t read_req_tag_0;
    phys_reg_tag_t read_req_tag_1;
    logic read_serviced;
    word_t read_data_0;
    word_t read_data_1;
    logic kill_valid;
    rob_index_t kill_rob_index;
    cbus_t [NUM_CBUS-1:0] cbus;
    logic complete_valid;
    logic restart_valid;
    restart_t restart;
    logic bp_update_valid;
    bp_update_t bp_update;

    integer seed = 32'hd8d7c772;
    // scoreboard, oldest first
    expect_t expect_q[$];
    int done_count = 0;
    rob_index_t next_rob = '0;

    bru_pipeline #(
        .NUM_CBUS(NUM_CBUS)
    ) i_bru_pipeline (
        .CLK            (CLK),
        .nRST           (nRST),
        .dispatch_valid (dispatch_valid),
        .dispatch_task  (dispatch_task),
        .rs_full        (rs_full),
        .read_req_valid (read_req_valid),
        .read_req_tag_0 (read_req_tag_0),
        .read_req_tag_1 (read_req_tag_1),
        .read_serviced  (read_serviced),
        .read_data_0    (read_data_0),
        .read_data_1    (read_data_1),
        .kill_valid     (kill_valid),
        .kill_rob_index (kill_rob_index),
        .cbus           (cbus),
        .complete_valid (complete_valid),
        .restart_valid  (restart_valid),
        .restart        (restart),
        .bp_update_valid(bp_update_valid),
        .bp_update      (bp_update)
    );

    // 4 ns period
    always #2 CLK = ~CLK;

    ////////////////////
    // failure reporting

    task automatic stop_with_failure();
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic rule_broken(input string what);
        $display("error at %0t ns: %s", $time, what);
        stop_with_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
        input logic [31:0] want);
        assert (got === want) else begin
            $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, want);
            stop_with_failure();
        end
    endtask

    ////////////////////
    // output rules

    // quiet while in reset
    assert property (@(posedge CLK) !nRST |->
        !(complete_valid || restart_valid || bp_update_valid || read_req_valid || rs_full))
    else rule_broken("output active during reset");

    assert property (@(posedge CLK) disable iff (!nRST) restart_valid |-> complete_valid)
    else rule_broken("restart without a completion");

    assert property (@(posedge CLK) disable iff (!nRST) bp_update_valid |-> complete_valid)
    else rule_broken("predictor update without a completion");

    // unserviced read keeps the station busy
    assert property (@(posedge CLK) disable iff (!nRST)
        (read_req_valid && !read_serviced) |-> rs_full)
    else rule_broken("unserviced read without rs_full");

    ////////////////////
    // reference rules

    function automatic expect_t reference(input bru_task_t t, input word_t a, input word_t b);
        expect_t e;
        logic [31:0] wide;
        pc_t seq;
        e = '0;
        seq = t.pc + pc_t'(1);
        // target is pc + 1 + sign-extended imm, wrapped to pc width
        wide = 32'(t.pc) + 32'd1 + {{16{t.imm16[15]}}, t.imm16};
        e.target = wide[PC_WIDTH-1:0];
        e.taken = (t.op == BRU_BEQ) ? (a == b) : ((t.op == BRU_BNE) ? (a != b) : 1'b0);
        if (t.op == BRU_JR) begin
            e.restart_pc = a[PC_WIDTH+1:2];
        end else if (e.taken) begin
            e.restart_pc = e.target;
        end else begin
            e.restart_pc = seq;
        end
        e.restart = (t.npc != e.restart_pc);
        e.bp_valid = (t.op != BRU_JR);
        e.index = t.pc[3:0];
        e.rob_index = t.rob_index;
        e.checkpoint_column = t.checkpoint_column;
        return e;
    endfunction

    // jr needs only source 0
    function automatic bru_task_t make_task(input bru_op_t op, input logic ready,
        input phys_reg_tag_t tag_0, input phys_reg_tag_t tag_1);
        bru_task_t t;
        t = '0;
        t.op = op;
        t.source_0.needed = 1'b1;
        t.source_0.ready = ready;
        t.source_0.phys_reg_tag = tag_0;
        t.source_1.needed = (op != BRU_JR);
        t.source_1.ready = ready;
        t.source_1.phys_reg_tag = tag_1;
        t.imm16 = 16'($random(seed));
        t.pc = pc_t'($random(seed));
        t.npc = t.pc + pc_t'(1);
        t.checkpoint_column = checkpoint_column_t'($random(seed));
        t.rob_index = next_rob;
        return t;
    endfunction

    ////////////////////
    // scoreboard

    // sampled mid low phase, after the falling-edge drive settled
    always @(negedge CLK) begin
        expect_t e;
        #1;
        if (nRST && complete_valid) begin
            if (expect_q.size() == 0) begin
                rule_broken("completion with no task outstanding");
            end else begin
                e = expect_q.pop_front();
                check_value("restart.rob_index", 32'(restart.rob_index), 32'(e.rob_index));
                check_value("restart_valid", 32'(restart_valid), 32'(e.restart));
                if (e.restart) begin
                    check_value("restart.pc", 32'(restart.pc), 32'(e.restart_pc));
                    check_value("restart.checkpoint_column",
                        32'(restart.checkpoint_column), 32'(e.checkpoint_column));
                end
                check_value("bp_update_valid", 32'(bp_update_valid), 32'(e.bp_valid));
                if (e.bp_valid) begin
                    check_value("bp_update.taken", 32'(bp_update.taken), 32'(e.taken));
                    check_value("bp_update.target", 32'(bp_update.target), 32'(e.target));
                    check_value("bp_update.index", 32'(bp_update.index), 32'(e.index));
                end
                done_count++;
            end
        end
    end

    ////////////////////
    // drivers

    // one dispatch cycle, ends on the next falling edge
    task automatic dispatch(input bru_task_t t, input word_t a, input word_t b,
        input logic record);
        dispatch_valid = 1'b1;
        dispatch_task = t;
        if (record) begin
            expect_q.push_back(reference(t, a, b));
        end
        next_rob = next_rob + rob_index_t'(1);
        @(negedge CLK);
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_done(input int want);
        int cycles;
        cycles = 0;
        while (done_count < want) begin
            @(negedge CLK);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                rule_broken("timeout waiting for complete_valid");
            end
        end
    endtask

    // ready operands from the register file, random op and npc
    task automatic run_random(input int count);
        bru_task_t t;
        expect_t e;
        word_t a;
        word_t b;
        logic [31:0] r;
        int want;
        int i;
        for (i = 0; i < count; i++) begin
            r = $random(seed);
            t = make_task((r[1:0] == 2'd0) ? BRU_BEQ : ((r[1:0] == 2'd1) ? BRU_BNE : BRU_JR),
                1'b1, r[7:2], r[13:8]);
            a = $random(seed);
            b = r[16] ? a : $random(seed);
            e = reference(t, a, b);
            // half right, half a random guess
            t.npc = r[17] ? e.restart_pc : pc_t'($random(seed));
            read_data_0 = a;
            read_data_1 = b;
            read_serviced = 1'b1;
            want = done_count + 1;
            dispatch(t, a, b, 1'b1);
            wait_done(want);
            read_serviced = 1'b0;
        end
    endtask

    // both sources caught on buses, raw words are decoys
    task automatic run_forwarding();
        bru_task_t t;
        word_t a;
        word_t b;
        logic [1:0] bus_a;
        logic [1:0] bus_b;
        int want;
        int k;
        for (k = 0; k < NUM_CBUS; k++) begin
            bus_a = 2'(k);
            bus_b = 2'((k + 1) % NUM_CBUS);
            t = make_task((k == 1) ? BRU_BEQ : BRU_BNE, 1'b0, 6'd10, 6'd20);
            a = $random(seed);
            b = (k == 0) ? a : $random(seed);
            read_serviced = 1'b0;
            // raw words flip the compare when a source misses its bus
            read_data_0 = (a == b) ? ~a : b;
            read_data_1 = (a == b) ? (a ^ 32'd1) : a;
            want = done_count + 1;
            dispatch(t, a, b, 1'b1);
            // rs cycle: tags only
            cbus[bus_a].tag_valid = 1'b1;
            cbus[bus_a].tag = 6'd10;
            cbus[bus_b].tag_valid = 1'b1;
            cbus[bus_b].tag = 6'd20;
            #1;
            check_value("read_req_valid", 32'(read_req_valid), 32'd0);
            check_value("rs_full", 32'(rs_full), 32'd0);
            @(negedge CLK);
            // ex cycle: data a cycle behind the tags
            cbus = '0;
            cbus[bus_a].data = a;
            cbus[bus_b].data = b;
            wait_done(want);
            cbus = '0;
        end
    endtask

    task automatic run_read_stall();
        bru_task_t t;
        expect_t e;
        word_t a;
        int want;
        int i;
        t = make_task(BRU_BEQ, 1'b1, 6'd33, 6'd44);
        a = $random(seed);
        e = reference(t, a, a);
        // force a mispredict too
        t.npc = e.restart_pc + pc_t'(1);
        read_serviced = 1'b0;
        read_data_0 = a;
        read_data_1 = a;
        want = done_count + 1;
        dispatch(t, a, a, 1'b1);
        for (i = 0; i < 4; i++) begin
            #1;
            check_value("rs_full", 32'(rs_full), 32'd1);
            check_value("read_req_valid", 32'(read_req_valid), 32'd1);
            check_value("read_req_tag_0", 32'(read_req_tag_0), 32'd33);
            check_value("read_req_tag_1", 32'(read_req_tag_1), 32'd44);
            check_value("complete_valid", 32'(complete_valid), 32'd0);
            @(negedge CLK);
        end
        read_serviced = 1'b1;
        wait_done(want);
        read_serviced = 1'b0;
    endtask

    task automatic run_kill();
        bru_task_t t;
        int i;
        t = make_task(BRU_BNE, 1'b1, 6'd5, 6'd6);
        read_serviced = 1'b0;
        dispatch(t, '0, '0, 1'b0);
        // other index leaves the task alone
        kill_valid = 1'b1;
        kill_rob_index = t.rob_index + rob_index_t'(1);
        #1;
        check_value("rs_full", 32'(rs_full), 32'd1);
        @(negedge CLK);
        kill_rob_index = t.rob_index;
        @(negedge CLK);
        kill_valid = 1'b0;
        // a surviving task would issue now
        read_serviced = 1'b1;
        for (i = 0; i < WAIT_LIMIT; i++) begin
            #1;
            check_value("rs_full", 32'(rs_full), 32'd0);
            check_value("read_req_valid", 32'(read_req_valid), 32'd0);
            @(negedge CLK);
        end
        read_serviced = 1'b0;
    endtask

    task automatic run_restart_flush();
        bru_task_t first;
        bru_task_t second;
        bru_task_t third;
        expect_t e;
        word_t a;
        int want;
        int i;
        // jr with a wrong npc
        first = make_task(BRU_JR, 1'b1, 6'd1, 6'd2);
        a = $random(seed);
        e = reference(first, a, a);
        first.npc = e.restart_pc + pc_t'(3);
        read_serviced = 1'b0;
        read_data_0 = a;
        read_data_1 = ~a;
        want = done_count + 1;
        dispatch(first, a, a, 1'b1);
        // first issues as second arrives behind it
        read_serviced = 1'b1;
        second = make_task(BRU_BEQ, 1'b1, 6'd3, 6'd4);
        dispatch(second, a, ~a, 1'b0);
        // restart cycle, second waiting in the rs
        read_serviced = 1'b0;
        #1;
        check_value("restart_valid", 32'(restart_valid), 32'd1);
        check_value("rs_full", 32'(rs_full), 32'd1);
        @(negedge CLK);
        read_serviced = 1'b1;
        for (i = 0; i < WAIT_LIMIT; i++) begin
            #1;
            check_value("rs_full", 32'(rs_full), 32'd0);
            check_value("read_req_valid", 32'(read_req_valid), 32'd0);
            @(negedge CLK);
        end
        check_value("done_count", 32'(done_count), 32'(want));
        // pipeline picks up again
        third = make_task(BRU_BNE, 1'b1, 6'd7, 6'd8);
        e = reference(third, a, ~a);
        third.npc = e.restart_pc;
        want = done_count + 1;
        dispatch(third, a, ~a, 1'b1);
        wait_done(want);
        read_serviced = 1'b0;
    endtask

    ////////////////////
    // main sequence

    initial begin
        nRST = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_task = '0;
        read_serviced = 1'b0;
        read_data_0 = '0;
        read_data_1 = '0;
        kill_valid = 1'b0;
        kill_rob_index = '0;
        cbus = '0;
        repeat (5) @(negedge CLK);
        nRST = 1'b1;
        #1;
        check_value("complete_valid", 32'(complete_valid), 32'd0);
        check_value("restart_valid", 32'(restart_valid), 32'd0);
        check_value("bp_update_valid", 32'(bp_update_valid), 32'd0);
        check_value("read_req_valid", 32'(read_req_valid), 32'd0);
        check_value("rs_full", 32'(rs_full), 32'd0);
        @(negedge CLK);
        run_random(40);
        run_forwarding();
        run_read_stall();
        run_kill();
        run_restart_flush();
        if (expect_q.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("error: %0d expected completions never seen", expect_q.size());
            stop_with_failure();
        end
    end

endmodule

// File: list.f
common/bru_pkg.sv
bru/bru_tag_match.sv
bru/bru_rs_stage.sv
bru/bru_ex_stage.sv
hdl/bru_pipeline.sv
testbench/tb_bru_pipeline.sv

// File: run.sh
#!/bin/sh
# build the branch resolution testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 \
    --top-module tb_bru_pipeline \
    -f list.f \
    -o tb_bru_pipeline \
    && ./obj_dir/tb_bru_pipeline \
    || exit 1
